// ==== weight_op_pkg.sv ====
package weight_op_pkg;

    // instruction word, top to bottom: opcode | lane index | column index
    typedef enum logic [1:0] {
        op_load      = 2'd0,
        op_read      = 2'd1,
        op_increment = 2'd2,
        op_nop       = 2'd3
    } weight_op_t;

    localparam int op_bits = 2; // width of the opcode field
    localparam int col_lsb = 0; // column index sits at the bottom

    // lane index starts right above the column bits
    function automatic int lane_lsb(int depth);
        return col_lsb + $clog2(depth);
    endfunction

    // opcode occupies the top bits
    function automatic int op_lsb(int lane_count, int depth);
        return lane_lsb(depth) + $clog2(lane_count);
    endfunction

endpackage

// ==== weight_arith_pkg.sv ====
package weight_arith_pkg;

    localparam int delta_bits = 2; // per-lane increment width

    typedef logic signed [delta_bits-1:0] delta_t; // -2 .. +1

    function automatic int w_max(int bits);
        return (1 << (bits - 1)) - 1;
    endfunction

    function automatic int w_min(int bits);
        return -(1 << (bits - 1));
    endfunction

    // clamp weight + delta to the signed range of a bits-wide weight
    function automatic int sat_add(int weight, delta_t delta, int bits);
        int sum;
        sum = weight + int'(delta);
        if (sum > w_max(bits)) return w_max(bits);
        if (sum < w_min(bits)) return w_min(bits);
        return sum;
    endfunction

endpackage

// ==== weight_store.sv ====
`timescale 1ns/1ps

module weight_store #(
    parameter int lane_count  = 16,
    parameter int depth       = 8,
    parameter int weight_bits = 8
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         mem_we,
    input  logic [$clog2(lane_count)+$clog2(depth)-1:0]  mem_addr,
    input  logic [weight_bits-1:0]                       mem_wdata,
    output logic [weight_bits-1:0]                       mem_rdata
);

    localparam int entries = lane_count * depth;

    // address is {lane, column}
    logic [weight_bits-1:0] mem [entries];

    assign mem_rdata = mem[mem_addr]; // combinational read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < entries; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

endmodule

// ==== host_cmd_unit.sv ====
`timescale 1ns/1ps

module host_cmd_unit #(
    parameter int lane_count  = 16,
    parameter int depth       = 8,
    parameter int weight_bits = 8
) (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [weight_op_pkg::op_bits+$clog2(lane_count)+$clog2(depth)-1:0] inst,
    input  logic [weight_bits-1:0]                                       data,
    input  logic                                                         exec,
    input  logic                                                         host_gnt,
    input  logic [weight_bits-1:0]                                       mem_rdata,
    output logic                                                         host_req,
    output logic                                                         host_we,
    output logic [$clog2(lane_count)+$clog2(depth)-1:0]                  host_addr,
    output logic [weight_bits-1:0]                                       host_wdata,
    output logic [weight_bits-1:0]                                       read_reg,
    output logic                                                         read_valid
);

    import weight_op_pkg::*;

    localparam int addr_bits = $clog2(lane_count) + $clog2(depth);
    localparam int opcode_lsb = op_lsb(lane_count, depth);

    weight_op_t opcode;
    logic       req_q;
    logic       we_q;
    logic       rd_hit;

    assign opcode = weight_op_t'(inst[opcode_lsb +: op_bits]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            req_q <= exec && (opcode == op_load || opcode == op_read); // one cycle only
            we_q  <= (opcode == op_load);
        end
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            host_addr  <= inst[col_lsb +: addr_bits]; // {lane, column}
            host_wdata <= data;
        end
    end

    assign host_req = req_q;
    assign host_we  = we_q;
    assign rd_hit   = host_req && host_gnt && !host_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_reg   <= '0;
            read_valid <= 1'b0;
        end else begin
            read_valid <= rd_hit;
            if (rd_hit) read_reg <= mem_rdata;
        end
    end

endmodule

// ==== increment_engine.sv ====
`timescale 1ns/1ps

module increment_engine #(
    parameter int lane_count  = 16,
    parameter int depth       = 8,
    parameter int weight_bits = 8
) (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [weight_op_pkg::op_bits+$clog2(lane_count)+$clog2(depth)-1:0] inst,
    input  logic [weight_arith_pkg::delta_bits*lane_count-1:0]           data,
    input  logic                                                         exec,
    input  logic                                                         eng_gnt,
    input  logic [weight_bits-1:0]                                       mem_rdata,
    output logic                                                         eng_req,
    output logic [$clog2(lane_count)+$clog2(depth)-1:0]                  eng_addr,
    output logic [weight_bits-1:0]                                       eng_wdata,
    output logic                                                         busy
);

    import weight_op_pkg::*;
    import weight_arith_pkg::*;

    localparam int lane_bits  = $clog2(lane_count);
    localparam int col_bits   = $clog2(depth);
    localparam int opcode_lsb = op_lsb(lane_count, depth);

    typedef enum logic {
        eng_idle,
        eng_walk
    } eng_state_t;

    eng_state_t                         state;
    logic [lane_bits-1:0]               lane_idx;
    logic [col_bits-1:0]                col_q;
    logic [delta_bits*lane_count-1:0]   delta_q;
    weight_op_t                         opcode;
    logic                               start;
    logic                               last_lane;
    delta_t                             lane_delta;
    int                                 sum_sat;

    assign opcode    = weight_op_t'(inst[opcode_lsb +: op_bits]);
    assign start     = exec && (opcode == op_increment) && (state == eng_idle);
    assign last_lane = (lane_idx == lane_bits'(lane_count - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= eng_idle;
            lane_idx <= '0;
        end else begin
            case (state)
                eng_idle: begin
                    if (start) begin
                        state    <= eng_walk;
                        lane_idx <= '0;
                    end
                end
                eng_walk: begin
                    if (eng_gnt) begin // lane done this cycle
                        if (last_lane) begin
                            state <= eng_idle;
                        end else begin
                            lane_idx <= lane_idx + 1'b1;
                        end
                    end
                end
                default: state <= eng_idle;
            endcase
        end
    end

    // column and deltas latched with the accepted exec
    always_ff @(posedge clk) begin
        if (start) begin
            col_q   <= inst[col_lsb +: col_bits];
            delta_q <= data;
        end
    end

    assign lane_delta = delta_t'(delta_q[lane_idx*delta_bits +: delta_bits]);
    assign sum_sat    = sat_add(int'($signed(mem_rdata)), lane_delta, weight_bits);

    // read and write of the same lane share one granted cycle
    assign busy      = (state == eng_walk);
    assign eng_req   = busy;
    assign eng_addr  = {lane_idx, col_q};
    assign eng_wdata = sum_sat[weight_bits-1:0];

endmodule

// ==== weight_arbiter.sv ====
`timescale 1ns/1ps

module weight_arbiter #(
    parameter int lane_count  = 16,
    parameter int depth       = 8,
    parameter int weight_bits = 8
) (
    input  logic                                         host_req,
    input  logic                                         host_we,
    input  logic [$clog2(lane_count)+$clog2(depth)-1:0]  host_addr,
    input  logic [weight_bits-1:0]                       host_wdata,
    input  logic                                         eng_req,
    input  logic [$clog2(lane_count)+$clog2(depth)-1:0]  eng_addr,
    input  logic [weight_bits-1:0]                       eng_wdata,
    output logic                                         host_gnt,
    output logic                                         eng_gnt,
    output logic                                         mem_we,
    output logic [$clog2(lane_count)+$clog2(depth)-1:0]  mem_addr,
    output logic [weight_bits-1:0]                       mem_wdata
);

    // host always wins, engine waits
    assign host_gnt = host_req;
    assign eng_gnt  = eng_req && !host_req;

    always_comb begin
        if (host_req) begin
            mem_we    = host_we;
            mem_addr  = host_addr;
            mem_wdata = host_wdata;
        end else begin
            mem_we    = eng_gnt; // engine access is always a write
            mem_addr  = eng_addr;
            mem_wdata = eng_wdata;
        end
    end

endmodule

// ==== weight_manager.sv ====
`timescale 1ns/1ps

module weight_manager #(
    parameter int lane_count  = 16,
    parameter int depth       = 8,
    parameter int weight_bits = 8
) (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [weight_op_pkg::op_bits+$clog2(lane_count)+$clog2(depth)-1:0] inst,
    input  logic [weight_arith_pkg::delta_bits*lane_count-1:0]           data,
    input  logic                                                         exec,
    output logic [weight_bits-1:0]                                       read_reg,
    output logic                                                         read_valid,
    output logic                                                         busy
);

    localparam int addr_bits = $clog2(lane_count) + $clog2(depth);

    logic                   host_req;
    logic                   host_we;
    logic [addr_bits-1:0]   host_addr;
    logic [weight_bits-1:0] host_wdata;
    logic                   host_gnt;
    logic                   eng_req;
    logic [addr_bits-1:0]   eng_addr;
    logic [weight_bits-1:0] eng_wdata;
    logic                   eng_gnt;
    logic                   mem_we;
    logic [addr_bits-1:0]   mem_addr;
    logic [weight_bits-1:0] mem_wdata;
    logic [weight_bits-1:0] mem_rdata;

    host_cmd_unit #(
        .lane_count(lane_count), .depth(depth), .weight_bits(weight_bits)
    ) u_host (
        .clk(clk), .rst_n(rst_n), .inst(inst),
        .data(data[weight_bits-1:0]), // load value in the low bits
        .exec(exec), .host_gnt(host_gnt), .mem_rdata(mem_rdata),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .read_reg(read_reg), .read_valid(read_valid)
    );

    increment_engine #(
        .lane_count(lane_count), .depth(depth), .weight_bits(weight_bits)
    ) u_engine (
        .clk(clk), .rst_n(rst_n), .inst(inst), .data(data), .exec(exec),
        .eng_gnt(eng_gnt), .mem_rdata(mem_rdata), .eng_req(eng_req),
        .eng_addr(eng_addr), .eng_wdata(eng_wdata), .busy(busy)
    );

    weight_arbiter #(
        .lane_count(lane_count), .depth(depth), .weight_bits(weight_bits)
    ) u_arbiter (
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .eng_req(eng_req), .eng_addr(eng_addr),
        .eng_wdata(eng_wdata), .host_gnt(host_gnt), .eng_gnt(eng_gnt),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    weight_store #(
        .lane_count(lane_count), .depth(depth), .weight_bits(weight_bits)
    ) u_store (
        .clk(clk), .rst_n(rst_n), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

// ==== weight_checker.sv ====
`timescale 1ns/1ps

module weight_checker #(
    parameter int lane_count  = 16,
    parameter int depth       = 8,
    parameter int weight_bits = 8
) (
    input  logic                                                                 clk,
    input  logic                                                                 rst_n,
    input  logic [weight_op_pkg::op_bits+$clog2(lane_count)+$clog2(depth)-1:0]   inst,
    input  logic [weight_arith_pkg::delta_bits*lane_count-1:0]                   data,
    input  logic                                                                 exec,
    input  logic [weight_bits-1:0]                                               read_reg,
    input  logic                                                                 read_valid,
    input  logic                                                                 busy,
    output int                                                                   reads_checked,
    output int                                                                   error_count,
    output int                                                                   ignored_count
);

    import weight_op_pkg::*;
    import weight_arith_pkg::*;

    localparam int lane_bits = $clog2(lane_count);
    localparam int col_bits  = $clog2(depth);
    localparam int w_hi      = (1 << (weight_bits - 1)) - 1;
    localparam int w_lo      = -(1 << (weight_bits - 1));

    int                               ref_mem [lane_count][depth];
    logic                             walking;
    int                               eng_lane;
    int                               eng_col;
    logic [delta_bits*lane_count-1:0] eng_deltas;
    logic                             host_pend;
    logic                             pend_is_load;
    int                               pend_lane;
    int                               pend_col;
    int                               pend_value;
    logic                             exp_valid;
    int                               exp_reg;
    int                               exp_lane;
    int                               exp_col;

    function automatic int clamp_weight(input int v);
        if (v > w_hi) return w_hi;
        if (v < w_lo) return w_lo;
        return v;
    endfunction

    function automatic int lane_delta(input logic [delta_bits*lane_count-1:0] d, input int l);
        return int'($signed(d[l*delta_bits +: delta_bits]));
    endfunction

    task automatic reset_model();
        for (int l = 0; l < lane_count; l++) begin
            for (int c = 0; c < depth; c++) begin
                ref_mem[l][c] = 0;
            end
        end
        walking       = 1'b0;
        eng_lane      = 0;
        eng_col       = 0;
        eng_deltas    = '0;
        host_pend     = 1'b0;
        pend_is_load  = 1'b0;
        exp_valid     = 1'b0;
        exp_reg       = 0;
        exp_lane      = 0;
        exp_col       = 0;
        reads_checked = 0;
        error_count   = 0;
        ignored_count = 0;
    endtask

    // outputs as they stand after the last rising edge
    task automatic compare_outputs();
        if (busy !== walking) begin
            error_count++;
            $display("ERROR at %0t: busy is %b, expected %b", $time, busy, walking);
        end
        if (exp_valid) begin
            reads_checked++;
            if (read_valid !== 1'b1) begin
                error_count++;
                $display("missing read_valid one cycle after the read of lane %0d column %0d (at %0t)",
                         exp_lane, exp_col, $time);
            end
        end else if (read_valid !== 1'b0) begin
            error_count++;
            $display("ERROR at %0t: read_valid pulsed with no read pending", $time);
        end
        if (read_reg !== weight_bits'(exp_reg)) begin
            error_count++;
            $display("ERROR at %0t: read_reg is %0d, expected %0d (lane %0d column %0d)",
                     $time, $signed(read_reg), exp_reg, exp_lane, exp_col);
        end
    endtask

    // effects of the coming rising edge
    task automatic step_model();
        logic       walk_before;
        weight_op_t op;
        int         lane;
        int         col;
        walk_before = walking;
        exp_valid   = 1'b0;
        if (host_pend) begin // engine stalls while the host owns the port
            if (pend_is_load) begin
                ref_mem[pend_lane][pend_col] = pend_value;
            end else begin
                exp_valid = 1'b1;
                exp_reg   = ref_mem[pend_lane][pend_col];
                exp_lane  = pend_lane;
                exp_col   = pend_col;
            end
        end else if (walking) begin
            ref_mem[eng_lane][eng_col] = clamp_weight(ref_mem[eng_lane][eng_col]
                                                      + lane_delta(eng_deltas, eng_lane));
            if (eng_lane == lane_count - 1) begin
                walking = 1'b0;
            end else begin
                eng_lane++;
            end
        end
        host_pend = 1'b0;
        if (exec) begin
            op   = weight_op_t'(inst[col_bits + lane_bits +: op_bits]);
            lane = int'(inst[col_bits +: lane_bits]);
            col  = int'(inst[col_bits-1:0]);
            case (op)
                op_load, op_read: begin
                    host_pend    = 1'b1;
                    pend_is_load = (op == op_load);
                    pend_lane    = lane;
                    pend_col     = col;
                    pend_value   = int'($signed(data[weight_bits-1:0]));
                end
                op_increment: begin
                    if (walk_before) begin
                        ignored_count++; // exec dropped while busy
                    end else begin
                        walking    = 1'b1;
                        eng_lane   = 0;
                        eng_col    = col;
                        eng_deltas = data;
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            reset_model();
        end else begin
            compare_outputs();
            step_model();
        end
    end

endmodule

// ==== tb_weight_manager.sv ====
`timescale 1ns/1ps

module tb_weight_manager;

    import weight_op_pkg::*;

    localparam int lane_count  = 16;
    localparam int depth       = 8;
    localparam int weight_bits = 8;
    localparam int lane_bits   = $clog2(lane_count);
    localparam int col_bits    = $clog2(depth);
    localparam int inst_bits   = op_bits + lane_bits + col_bits;
    localparam int data_bits   = 2 * lane_count;
    localparam int max_rows    = 512;
    localparam int no_wait     = 0;
    localparam int for_read    = 1;
    localparam int for_idle    = 2;
    localparam int read_limit  = 8;
    localparam int idle_limit  = 2 * lane_count + 16;

    logic                   clk;
    logic                   rst_n;
    logic [inst_bits-1:0]   inst;
    logic [data_bits-1:0]   data;
    logic                   exec;
    logic [weight_bits-1:0] read_reg;
    logic                   read_valid;
    logic                   busy;
    int                     reads_checked;
    int                     error_count;
    int                     ignored_count;

    // stimulus table
    weight_op_t           row_op   [max_rows];
    int                   row_lane [max_rows];
    int                   row_col  [max_rows];
    logic [data_bits-1:0] row_data [max_rows];
    int                   row_wait [max_rows];
    int                   row_test [max_rows];
    int                   n_rows;
    string                test_name [5];
    logic [31:0]          rng;
    logic                 hung;
    int                   last_reads;
    int                   last_errors;

    weight_manager #(
        .lane_count(lane_count), .depth(depth), .weight_bits(weight_bits)
    ) dut (
        .clk(clk), .rst_n(rst_n), .inst(inst), .data(data), .exec(exec),
        .read_reg(read_reg), .read_valid(read_valid), .busy(busy)
    );

    weight_checker #(
        .lane_count(lane_count), .depth(depth), .weight_bits(weight_bits)
    ) u_checker (
        .clk(clk), .rst_n(rst_n), .inst(inst), .data(data), .exec(exec),
        .read_reg(read_reg), .read_valid(read_valid), .busy(busy),
        .reads_checked(reads_checked), .error_count(error_count),
        .ignored_count(ignored_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input weight_op_t op, input int lane, input int col,
                           input logic [data_bits-1:0] value, input int wait_kind, input int t);
        row_op[n_rows]   = op;
        row_lane[n_rows] = lane;
        row_col[n_rows]  = col;
        row_data[n_rows] = value;
        row_wait[n_rows] = wait_kind;
        row_test[n_rows] = t;
        n_rows++;
    endtask

    task automatic fill_table();
        logic [data_bits-1:0] pattern;
        int                   w_hi;
        int                   w_lo;
        w_hi = (1 << (weight_bits - 1)) - 1;
        w_lo = -(1 << (weight_bits - 1));
        test_name[0] = "reads after reset";
        test_name[1] = "load and read back";
        test_name[2] = "column increment";
        test_name[3] = "saturation";
        test_name[4] = "increment under host traffic";
        add_row(op_read, 0, 0, '0, for_read, 0);
        add_row(op_read, 5, 3, '0, for_read, 0);
        add_row(op_read, lane_count - 1, depth - 1, '0, for_read, 0);
        add_row(op_read, 9, 1, '0, for_read, 0);
        for (int l = 0; l < lane_count; l++) begin
            for (int c = 0; c < depth; c++) begin
                rng = lcg_next(rng);
                add_row(op_load, l, c, data_bits'(rng >> (32 - weight_bits)), no_wait, 1);
            end
        end
        for (int l = 0; l < lane_count; l++) begin
            for (int c = 0; c < depth; c++) begin
                add_row(op_read, l, c, '0, for_read, 1);
            end
        end
        rng = lcg_next(rng);
        add_row(op_increment, 0, 2, data_bits'(rng), for_idle, 2);
        for (int l = 0; l < lane_count; l++) begin
            for (int c = 0; c < depth; c++) begin
                add_row(op_read, l, c, '0, for_read, 2); // whole store, other columns too
            end
        end
        add_row(op_load, 0, 5, data_bits'(w_hi), no_wait, 3);
        add_row(op_load, 1, 5, data_bits'(w_lo), no_wait, 3);
        add_row(op_load, 2, 5, data_bits'(w_hi - 1), no_wait, 3);
        add_row(op_load, 3, 5, data_bits'(w_lo + 1), no_wait, 3);
        rng = lcg_next(rng);
        pattern      = data_bits'(rng);
        pattern[7:0] = 8'b10_01_10_01; // lanes 0..3 get +1 -2 +1 -2
        add_row(op_increment, 0, 5, pattern, for_idle, 3);
        for (int l = 0; l < lane_count; l++) begin
            add_row(op_read, l, 5, '0, for_read, 3);
        end
        rng = lcg_next(rng);
        add_row(op_increment, 0, 6, data_bits'(rng), no_wait, 4);
        rng = lcg_next(rng);
        add_row(op_increment, 0, 7, data_bits'(rng), no_wait, 4); // lands while busy
        rng = lcg_next(rng);
        add_row(op_load, lane_count - 4, 6, data_bits'(rng >> (32 - weight_bits)), no_wait, 4);
        rng = lcg_next(rng);
        add_row(op_load, 1, 6, data_bits'(rng >> (32 - weight_bits)), no_wait, 4);
        add_row(op_read, 0, 6, '0, for_read, 4);
        add_row(op_nop, 0, 0, '0, for_idle, 4);
        for (int l = 0; l < lane_count; l++) begin
            add_row(op_read, l, 6, '0, for_read, 4);
        end
        for (int l = 0; l < 4; l++) begin
            add_row(op_read, l, 7, '0, for_read, 4);
        end
    endtask

    task automatic poll_read_valid(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < read_limit && !ok; n++) begin
            @(negedge clk);
            if (read_valid) ok = 1'b1;
        end
        if (!ok) $display("timeout: read_valid never came within %0d cycles of a read", read_limit);
    endtask

    task automatic wait_engine_idle(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < idle_limit && !ok; n++) begin
            @(negedge clk);
            if (!busy) ok = 1'b1;
        end
        if (!ok) $display("timeout: busy stayed high for %0d cycles", idle_limit);
    endtask

    task automatic apply_row(input int i);
        logic ok;
        @(posedge clk);
        inst <= {row_op[i], lane_bits'(row_lane[i]), col_bits'(row_col[i])};
        data <= row_data[i];
        exec <= 1'b1;
        @(posedge clk);
        exec <= 1'b0;
        ok = 1'b1;
        if (row_wait[i] == for_read) begin
            poll_read_valid(ok);
        end else if (row_wait[i] == for_idle) begin
            wait_engine_idle(ok);
        end
        if (!ok) hung = 1'b1;
    endtask

    task automatic report_test(input int t);
        repeat (2) @(posedge clk); // let the last compare settle
        $display("test %0d, %s: %0d reads checked, %0d errors", t + 1, test_name[t],
                 reads_checked - last_reads, error_count - last_errors);
        last_reads  = reads_checked;
        last_errors = error_count;
    endtask

    initial begin
        int cur_test;
        rst_n       = 1'b0;
        inst        = '0;
        data        = '0;
        exec        = 1'b0;
        hung        = 1'b0;
        rng         = 32'haab8bd35;
        n_rows      = 0;
        last_reads  = 0;
        last_errors = 0;
        fill_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        cur_test = row_test[0];
        for (int i = 0; i < n_rows && !hung; i++) begin
            if (row_test[i] != cur_test) begin
                report_test(cur_test);
                cur_test = row_test[i];
            end
            apply_row(i);
        end
        report_test(cur_test);
        $display("summary: %0d reads checked, %0d errors, %0d increments ignored while busy",
                 reads_checked, error_count, ignored_count);
        if (error_count == 0 && !hung) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== weight_manager.f ====
weight_op_pkg.sv
weight_arith_pkg.sv
weight_store.sv
host_cmd_unit.sv
increment_engine.sv
weight_arbiter.sv
weight_manager.sv
weight_checker.sv
tb_weight_manager.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_weight_manager \
    -f weight_manager.f -o sim_tb_weight_manager

output=$(./obj_dir/sim_tb_weight_manager)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
